// ==== logic/byteRam.sv ====
`timescale 1ns/1ps

module byteRam (
    input  logic           clk,
    input  memPkg::ramAddrT addr,
    input  logic           we,
    input  memPkg::byteT   wData,
    output memPkg::byteT   rData
);

    memPkg::byteT mem [0:memPkg::RamDepth-1];

    // contents start cleared
    initial begin
        for (int i = 0; i < memPkg::RamDepth; i++) begin
            mem[i] = '0;
        end
    end

    // read-before-write on a same-address collision
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wData;
        end
        rData <= mem[addr];
    end

endmodule

// ==== logic/fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit (
    input  logic         clk,
    input  logic         rst,
    input  logic         jumpEn,
    input  memPkg::addrT jumpAddr,
    input  logic         instTake,
    input  logic         infDone,
    input  memPkg::wordT infInst,
    output logic         infEn,
    output memPkg::addrT infAddr,
    output logic         instValid,
    output memPkg::wordT inst,
    output memPkg::addrT instPc
);

    memPkg::addrT pc;
    memPkg::wordT instBuf;
    logic         valid;
    logic         discard;

    // ask whenever the buffer is empty
    assign infEn = !valid;
    assign infAddr = pc;
    assign instValid = valid;
    assign inst = instBuf;
    assign instPc = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            valid <= 1'b0;
            discard <= 1'b0;
        end else if (jumpEn) begin
            pc <= jumpAddr;
            valid <= 1'b0;
            // a fetch may still be on its way from the old pc
            discard <= !valid && !infDone;
        end else if (infDone) begin
            if (discard) begin
                discard <= 1'b0;
            end else begin
                valid <= 1'b1;
            end
        end else if (instTake && valid) begin
            valid <= 1'b0;
            pc <= pc + memPkg::addrT'(memPkg::WordBytes);
        end
    end

    always_ff @(posedge clk) begin
        if (infDone) begin
            instBuf <= infInst;
        end
    end

endmodule

// ==== logic/memCtrl.sv ====
`timescale 1ns/1ps

module memCtrl (
    input  logic            clk,
    input  logic            rst,
    input  logic            rdy,
    input  logic            ioBufferFull,

    input  logic            dcEn,
    input  logic            dcStore,
    input  memPkg::addrT    dcAddr,
    input  memPkg::lenT     dcLen,
    input  memPkg::wordT    dcWData,
    output logic            dcDone,
    output memPkg::wordT    dcRData,

    input  logic            infEn,
    input  memPkg::addrT    infAddr,
    output logic            infDone,
    output memPkg::wordT    infInst,

    output memPkg::ramAddrT ramAddr,
    output logic            ramWe,
    output memPkg::byteT    ramWData,
    input  memPkg::byteT    ramRData
);

    memPkg::ctrlStateT state;
    memPkg::lenT       stage;
    memPkg::lenT       lenReg;
    memPkg::ramAddrT   baseAddr;
    memPkg::wordT      wordBuf;

    logic         stall;
    logic         accept;
    logic         reading;
    logic         lastWrite;
    logic         readDone;
    memPkg::lenT  byteIdx;
    logic [4:0]   shiftAmt;
    memPkg::wordT assembled;

    assign stall = !rdy || ioBufferFull;
    assign accept = (state == memPkg::idle) && !stall && (dcEn || infEn);
    assign reading = (state == memPkg::readInst) || (state == memPkg::readData);
    assign lastWrite = (stage + memPkg::lenT'(1)) == lenReg;
    assign readDone = reading && (stage == lenReg);

    // while stalled, keep the previous byte on the RAM so that its data
    // is still there for the capture once the stall ends
    assign byteIdx = (stall && stage != '0) ? stage - memPkg::lenT'(1) : stage;

    assign ramAddr = baseAddr + memPkg::ramAddrT'(byteIdx);
    assign ramWe = !stall && (state == memPkg::writeData);
    assign ramWData = wordBuf[memPkg::ByteWidth-1:0];

    // last byte comes straight from the RAM, short loads shift down
    // which also zero-extends them
    assign shiftAmt = 5'((memPkg::WordBytes - int'(lenReg)) * memPkg::ByteWidth);
    assign assembled = {ramRData, wordBuf[memPkg::WordWidth-1:memPkg::ByteWidth]} >> shiftAmt;

    assign dcDone = !stall && ((state == memPkg::readData && readDone) ||
                               (state == memPkg::writeData && lastWrite));
    assign dcRData = assembled;
    assign infDone = !stall && (state == memPkg::readInst) && readDone;
    assign infInst = assembled;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= memPkg::idle;
            stage <= '0;
        end else if (!stall) begin
            case (state)
                memPkg::idle: begin
                    stage <= '0;
                    // data port first
                    if (dcEn) begin
                        state <= dcStore ? memPkg::writeData : memPkg::readData;
                    end else if (infEn) begin
                        state <= memPkg::readInst;
                    end
                end
                memPkg::readInst,
                memPkg::readData: begin
                    if (readDone) begin
                        state <= memPkg::idle;
                        stage <= '0;
                    end else begin
                        stage <= stage + memPkg::lenT'(1);
                    end
                end
                memPkg::writeData: begin
                    if (lastWrite) begin
                        state <= memPkg::idle;
                        stage <= '0;
                    end else begin
                        stage <= stage + memPkg::lenT'(1);
                    end
                end
                default: begin
                    state <= memPkg::idle;
                    stage <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (dcEn) begin
                baseAddr <= dcAddr[memPkg::RamAddrWidth-1:0];
                lenReg <= dcLen;
            end else begin
                baseAddr <= infAddr[memPkg::RamAddrWidth-1:0];
                lenReg <= memPkg::lenT'(memPkg::WordBytes);
            end
            wordBuf <= dcWData;
        end else if (!stall) begin
            if (state == memPkg::writeData) begin
                // next store byte into the low lane
                wordBuf <= wordBuf >> memPkg::ByteWidth;
            end else if (reading && stage != '0) begin
                // bytes enter at the top and move down
                wordBuf <= {ramRData, wordBuf[memPkg::WordWidth-1:memPkg::ByteWidth]};
            end
        end
    end

endmodule

// ==== logic/memPkg.sv ====
package memPkg;

    // processor side
    localparam int AddrWidth = 32;
    localparam int WordWidth = 32;
    localparam int ByteWidth = 8;

    // 1 KiB byte RAM, indexed by the low address bits
    localparam int RamAddrWidth = 10;
    localparam int RamDepth = 1 << RamAddrWidth;

    // access length in bytes, legal values 1, 2 and 4
    localparam int LenWidth = 3;

    // an instruction fetch is always a full word
    localparam int WordBytes = WordWidth / ByteWidth;

    typedef logic [AddrWidth-1:0] addrT;
    typedef logic [RamAddrWidth-1:0] ramAddrT;
    typedef logic [ByteWidth-1:0] byteT;
    typedef logic [WordWidth-1:0] wordT;
    typedef logic [LenWidth-1:0] lenT;

    typedef enum logic [1:0] {
        idle,
        readInst,
        readData,
        writeData
    } ctrlStateT;

endpackage

// ==== logic/memSystem.sv ====
`timescale 1ns/1ps

module memSystem (
    input  logic         clk,
    input  logic         rst,
    input  logic         rdy,
    input  logic         ioBufferFull,

    input  logic         dcEn,
    input  logic         dcStore,
    input  memPkg::addrT dcAddr,
    input  memPkg::lenT  dcLen,
    input  memPkg::wordT dcWData,
    output logic         dcDone,
    output memPkg::wordT dcRData,

    input  logic         jumpEn,
    input  memPkg::addrT jumpAddr,
    input  logic         instTake,
    output logic         instValid,
    output memPkg::wordT inst,
    output memPkg::addrT instPc
);

    logic            infEn;
    memPkg::addrT    infAddr;
    logic            infDone;
    memPkg::wordT    infInst;

    memPkg::ramAddrT ramAddr;
    logic            ramWe;
    memPkg::byteT    ramWData;
    memPkg::byteT    ramRData;

    fetchUnit fetch0 (
        .clk       (clk),
        .rst       (rst),
        .jumpEn    (jumpEn),
        .jumpAddr  (jumpAddr),
        .instTake  (instTake),
        .infDone   (infDone),
        .infInst   (infInst),
        .infEn     (infEn),
        .infAddr   (infAddr),
        .instValid (instValid),
        .inst      (inst),
        .instPc    (instPc)
    );

    memCtrl ctrl0 (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .dcEn         (dcEn),
        .dcStore      (dcStore),
        .dcAddr       (dcAddr),
        .dcLen        (dcLen),
        .dcWData      (dcWData),
        .dcDone       (dcDone),
        .dcRData      (dcRData),
        .infEn        (infEn),
        .infAddr      (infAddr),
        .infDone      (infDone),
        .infInst      (infInst),
        .ramAddr      (ramAddr),
        .ramWe        (ramWe),
        .ramWData     (ramWData),
        .ramRData     (ramRData)
    );

    byteRam ram0 (
        .clk   (clk),
        .addr  (ramAddr),
        .we    (ramWe),
        .wData (ramWData),
        .rData (ramRData)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# build the memory subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert --top-module memSystemTb -f sim.f -o simv &&
    ./obj_dir/simv; } > sim.log 2>&1 || echo "test failed" >> sim.log
grep -q "test failed" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
echo "simulation passed"
exit 0

// ==== sim.f ====
logic/memPkg.sv
logic/byteRam.sv
logic/memCtrl.sv
logic/fetchUnit.sv
logic/memSystem.sv
test/memSystem_props.sv
test/memSystemTb.sv

// ==== test/memSystemTb.sv ====
`timescale 1ns/1ps

module memSystemTb;

    localparam int Seed = 32'h196f;
    localparam int DoneTimeout = 100;
    localparam int FetchTimeout = 300;
    localparam int TimedAccesses = 60;
    localparam int MixedAccesses = 150;
    localparam int StalledAccesses = 300;
    localparam int MinTaken = 50;
    // program area is the lower half, stores only go to the upper half
    localparam memPkg::addrT JumpLimit = 32'h1c0;

    logic clk;
    logic rst;
    logic rdy;
    logic ioBufferFull;
    logic dcEn;
    logic dcStore;
    memPkg::addrT dcAddr;
    memPkg::lenT dcLen;
    memPkg::wordT dcWData;
    logic dcDone;
    memPkg::wordT dcRData;
    logic jumpEn;
    memPkg::addrT jumpAddr;
    logic instTake;
    logic instValid;
    memPkg::wordT inst;
    memPkg::addrT instPc;

    memPkg::byteT model [0:memPkg::RamDepth-1];
    bit stallOn;
    bit takeOn;
    bit jumpsOn;
    memPkg::addrT expPc;
    int taken;
    int emptyCycles;

    memSystem dut0 (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .ioBufferFull (ioBufferFull),
        .dcEn         (dcEn),
        .dcStore      (dcStore),
        .dcAddr       (dcAddr),
        .dcLen        (dcLen),
        .dcWData      (dcWData),
        .dcDone       (dcDone),
        .dcRData      (dcRData),
        .jumpEn       (jumpEn),
        .jumpAddr     (jumpAddr),
        .instTake     (instTake),
        .instValid    (instValid),
        .inst         (inst),
        .instPc       (instPc)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic stopRun();
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic reportError(input string msg);
        $display("%s", msg);
        stopRun();
    endtask

    task automatic checkWord(input string name, input memPkg::wordT actual,
                             input memPkg::wordT expected);
        if (actual !== expected) begin
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
            stopRun();
        end
    endtask

    task automatic checkAddr(input string name, input memPkg::addrT actual,
                             input memPkg::addrT expected);
        if (actual !== expected) begin
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
            stopRun();
        end
    endtask

    task automatic checkCount(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
            stopRun();
        end
    endtask

    // little-endian read of len bytes, zero-extended
    function automatic memPkg::wordT modelRead(input memPkg::addrT addr, input memPkg::lenT len);
        memPkg::wordT value;
        value = '0;
        for (int k = 0; k < int'(len); k++) begin
            value[8*k +: 8] = model[memPkg::ramAddrT'(addr + memPkg::addrT'(k))];
        end
        return value;
    endfunction

    task automatic modelWrite(input memPkg::addrT addr, input memPkg::lenT len,
                              input memPkg::wordT data);
        for (int k = 0; k < int'(len); k++) begin
            model[memPkg::ramAddrT'(addr + memPkg::addrT'(k))] = data[8*k +: 8];
        end
    endtask

    // falling edge: stalls, jumps and instruction takes
    task automatic driveEdge();
        @(negedge clk);
        rdy = !(stallOn && ($urandom % 100) < 15);
        ioBufferFull = stallOn && ($urandom % 100) < 15;
        jumpEn = 1'b0;
        instTake = 1'b0;
        if (takeOn) begin
            if (expPc >= JumpLimit || (jumpsOn && ($urandom % 64) == 0)) begin
                jumpEn = 1'b1;
                jumpAddr = memPkg::addrT'(($urandom % 112) * 4);
                expPc = jumpAddr;
            end else if (instValid && ($urandom % 2) == 0) begin
                checkAddr("instPc", instPc, expPc);
                checkWord("inst", inst, modelRead(expPc, memPkg::lenT'(4)));
                instTake = 1'b1;
                expPc = expPc + 4;
                taken++;
            end
            if (instValid) begin
                emptyCycles = 0;
            end else begin
                emptyCycles++;
            end
            if (emptyCycles > FetchTimeout) begin
                reportError("instruction buffer stayed empty too long");
            end
        end
    endtask

    task automatic sampleEdge();
        @(posedge clk);
        if (dcDone && (!rdy || ioBufferFull)) begin
            reportError("dcDone arrived in a stalled cycle");
        end
    endtask

    task automatic redirect(input memPkg::addrT target);
        @(negedge clk);
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        instTake = 1'b0;
        jumpEn = 1'b1;
        jumpAddr = target;
        expPc = target;
        sampleEdge();
    endtask

    task automatic waitForInst();
        int cycles;
        cycles = 0;
        while (!instValid) begin
            if (cycles >= FetchTimeout) begin
                reportError("no instruction arrived after reset");
            end
            driveEdge();
            sampleEdge();
            cycles++;
        end
    endtask

    // timed accesses need no stalls and no fetch already under way
    task automatic dataAccess(input logic store, input memPkg::addrT addr,
                              input memPkg::lenT len, input memPkg::wordT data,
                              input bit timed);
        memPkg::wordT expected;
        int cycles;
        expected = modelRead(addr, len);
        driveEdge();
        dcEn = 1'b1;
        dcStore = store;
        dcAddr = addr;
        dcLen = len;
        dcWData = data;
        cycles = 0;
        sampleEdge();
        while (!dcDone) begin
            if (cycles >= DoneTimeout) begin
                reportError("timed out waiting for dcDone");
            end
            driveEdge();
            sampleEdge();
            cycles++;
        end
        if (timed) begin
            checkCount("dcDone latency", cycles, store ? int'(len) : int'(len) + 1);
        end
        if (store) begin
            modelWrite(addr, len, data);
        end else begin
            checkWord("dcRData", dcRData, expected);
        end
        driveEdge();
        dcEn = 1'b0;
        sampleEdge();
    endtask

    task automatic randomAccess(input bit timed);
        int pick;
        logic store;
        memPkg::lenT len;
        memPkg::addrT addr;
        pick = int'($urandom % 3);
        len = (pick == 0) ? memPkg::lenT'(1) : ((pick == 1) ? memPkg::lenT'(2) : memPkg::lenT'(4));
        store = ($urandom % 2) == 1;
        addr = memPkg::addrT'($urandom % 1024) & ~(memPkg::addrT'(len) - memPkg::addrT'(1));
        if (store) begin
            addr = addr | 32'h200;
        end
        dataAccess(store, addr, len, $urandom, timed);
    endtask

    initial begin
        int target;
        int cycles;
        rst = 1'b1;
        rdy = 1'b1;
        ioBufferFull = 1'b0;
        dcEn = 1'b0;
        dcStore = 1'b0;
        dcAddr = '0;
        dcLen = memPkg::lenT'(1);
        dcWData = '0;
        jumpEn = 1'b0;
        jumpAddr = '0;
        instTake = 1'b0;
        stallOn = 1'b0;
        takeOn = 1'b0;
        jumpsOn = 1'b0;
        expPc = '0;
        taken = 0;
        emptyCycles = 0;
        void'($urandom(Seed));
        for (int i = 0; i < memPkg::RamDepth; i++) begin
            model[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        waitForInst();

        // program area, word stores with exact latency
        for (int a = 0; a < 'h200; a += 4) begin
            dataAccess(1'b1, memPkg::addrT'(a), memPkg::lenT'(4), $urandom, 1'b1);
        end
        repeat (TimedAccesses) randomAccess(1'b1);

        // the word buffered before the fill is stale
        redirect('0);
        // fetch and data ask in the same idle cycle, data goes first
        randomAccess(1'b1);
        takeOn = 1'b1;
        repeat (MixedAccesses) randomAccess(1'b0);

        stallOn = 1'b1;
        jumpsOn = 1'b1;
        repeat (StalledAccesses) randomAccess(1'b0);

        stallOn = 1'b0;
        jumpsOn = 1'b0;
        target = taken + 4;
        cycles = 0;
        while (taken < target) begin
            if (cycles >= FetchTimeout) begin
                reportError("instruction stream stopped at the end of the run");
            end
            driveEdge();
            sampleEdge();
            cycles++;
        end
        if (taken < MinTaken) begin
            reportError("too few instructions were taken");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// ==== test/memSystem_props.sv ====
`timescale 1ns/1ps

module memCtrlProps (
    input logic clk,
    input logic rst,
    input logic rdy,
    input logic ioBufferFull,
    input logic dcDone,
    input logic infDone,
    input logic ramWe
);

    logic stall;

    assign stall = !rdy || ioBufferFull;

    // one requester finishes at a time
    doneExclusive: assert property (@(posedge clk) disable iff (rst) !(dcDone && infDone))
        else $error("dcDone and infDone high together");

    // frozen cycle neither writes nor completes
    noWriteInStall: assert property (@(posedge clk) disable iff (rst) stall |-> !ramWe)
        else $error("ramWe high in a stalled cycle");
    noDoneInStall: assert property (@(posedge clk) disable iff (rst)
        stall |-> !(dcDone || infDone))
        else $error("done pulse in a stalled cycle");

    dcDonePulse: assert property (@(posedge clk) disable iff (rst) dcDone |=> !dcDone)
        else $error("dcDone longer than one cycle");
    infDonePulse: assert property (@(posedge clk) disable iff (rst) infDone |=> !infDone)
        else $error("infDone longer than one cycle");

endmodule

bind memCtrl memCtrlProps props0 (
    .clk          (clk),
    .rst          (rst),
    .rdy          (rdy),
    .ioBufferFull (ioBufferFull),
    .dcDone       (dcDone),
    .infDone      (infDone),
    .ramWe        (ramWe)
);
